// File: hdl/fp_config_pkg.sv
/* Sizing constants for the FP compare and min/max retirement path */

package fp_config_pkg;

  // ####################################################################
  // Tag space
  // ####################################################################
  localparam int MAX_IDS = 8;             // Tags in flight, queue and table depth
  localparam int ID_W    = 3;             // Tag width, 2**ID_W == MAX_IDS

  // ####################################################################
  // Data widths
  // ####################################################################
  localparam int FLEN     = 32;           // Single precision operand/result
  localparam int FFLAGS_W = 5;            // NV DZ OF UF NX

endpackage

// File: hdl/fp_types_pkg.sv
/* Opcodes, exception flag layout and float helpers for the compare and min/max ops */

package fp_types_pkg;
  import fp_config_pkg::*;

  typedef enum logic [2:0] {
    OP_FEQ  = 3'd0,
    OP_FLT  = 3'd1,
    OP_FLE  = 3'd2,
    OP_FMIN = 3'd3,
    OP_FMAX = 3'd4
  } fp_op_t;

  localparam int FLAG_NV = 4;             // Invalid operation
  localparam int FLAG_DZ = 3;             // Divide by zero
  localparam int FLAG_OF = 2;             // Overflow
  localparam int FLAG_UF = 1;             // Underflow
  localparam int FLAG_NX = 0;             // Inexact

  localparam logic [FLEN-1:0] CANON_NAN = 32'h7fc0_0000;

  function automatic logic f_is_nan(input logic [FLEN-1:0] x);
    return (&x[30:23]) && (|x[22:0]);     // Exp all ones, mantissa nonzero
  endfunction

  function automatic logic f_is_snan(input logic [FLEN-1:0] x);
    return f_is_nan(x) && !x[22];         // Quiet bit clear
  endfunction

  // Ordered less-than, +0 and -0 equal, NaN not handled here
  function automatic logic f_lt(input logic [FLEN-1:0] a, input logic [FLEN-1:0] b);
    if ((a[FLEN-2:0] == '0) && (b[FLEN-2:0] == '0))
      return 1'b0;
    if (a[FLEN-1] != b[FLEN-1])
      return a[FLEN-1];                   // Negative side is smaller
    if (a[FLEN-1])
      return a[FLEN-2:0] > b[FLEN-2:0];   // Both negative, larger magnitude smaller
    return a[FLEN-2:0] < b[FLEN-2:0];
  endfunction

  // These ops only ever raise NV
  function automatic logic [FFLAGS_W-1:0] f_mk_fflags(input logic nv);
    logic [FFLAGS_W-1:0] f;
    f          = '0;
    f[FLAG_NV] = nv;
    f[FLAG_DZ] = 1'b0;
    f[FLAG_OF] = 1'b0;
    f[FLAG_UF] = 1'b0;
    f[FLAG_NX] = 1'b0;
    return f;
  endfunction

endpackage

// File: hdl/fp_decode.sv
/* Decode: accepts instructions, hands out round-robin tags, tracks in-flight
   count and dispatches to the compare or min/max unit */

module fp_decode import fp_config_pkg::*, fp_types_pkg::*; (
  input  logic            clk,
  input  logic            rst_n,
  input  logic            in_valid,
  output logic            in_ready,
  input  fp_op_t          in_op,
  input  logic [FLEN-1:0] in_a,
  input  logic [FLEN-1:0] in_b,
  input  logic            retire_pulse,
  output logic            cmp_issue,
  output logic            mm_issue,
  output logic [ID_W-1:0] issue_id,
  output fp_op_t          issue_op,
  output logic [FLEN-1:0] issue_a,
  output logic [FLEN-1:0] issue_b,
  output logic            ord_push,
  output logic [ID_W-1:0] ord_id,
  output logic            ord_wb_float
);

  logic [ID_W:0]   inflight;              // 0..MAX_IDS
  logic [ID_W-1:0] next_id;
  logic            accept;
  logic            is_mm;

  assign in_ready = (inflight < MAX_IDS);                 // Room for another tag
  assign accept   = in_valid && in_ready;
  assign is_mm    = (in_op == OP_FMIN) || (in_op == OP_FMAX);

  // ####################################################################
  // Dispatch, same cycle as the input transfer
  // ####################################################################
  assign cmp_issue    = accept && !is_mm;
  assign mm_issue     = accept && is_mm;
  assign issue_id     = next_id;
  assign issue_op     = in_op;
  assign issue_a      = in_a;
  assign issue_b      = in_b;
  assign ord_push     = accept;           // Order queue entry alongside issue
  assign ord_id       = next_id;
  assign ord_wb_float = is_mm;            // Min/max writes a float result

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      inflight <= '0;
      next_id  <= '0;
    end else begin
      if (accept)
        next_id <= next_id + 1'b1;        // Wraps at MAX_IDS
      case ({accept, retire_pulse})
        2'b10:   inflight <= inflight + 1'b1;
        2'b01:   inflight <= inflight - 1'b1;
        default: ;                        // Both or neither, no change
      endcase
    end
  end

  a_inflight_bound: assert property (@(posedge clk) disable iff (!rst_n)
    inflight <= MAX_IDS);

endmodule

// File: hdl/fp_compare_unit.sv
/* Single-cycle feq/flt/fle unit, integer 0/1 result with NV detection */

module fp_compare_unit import fp_config_pkg::*, fp_types_pkg::*; (
  input  logic                clk,
  input  logic                rst_n,
  input  logic                issue,
  input  logic [ID_W-1:0]     issue_id,
  input  fp_op_t              issue_op,
  input  logic [FLEN-1:0]     issue_a,
  input  logic [FLEN-1:0]     issue_b,
  output logic                wb_valid,
  output logic [ID_W-1:0]     wb_id,
  output logic [FLEN-1:0]     wb_result,
  output logic [FFLAGS_W-1:0] wb_fflags
);

  logic any_nan, any_snan;
  logic lt, gt, eq;
  logic res, nv;

  always_comb begin
    any_nan  = f_is_nan(issue_a) || f_is_nan(issue_b);
    any_snan = f_is_snan(issue_a) || f_is_snan(issue_b);
    lt       = f_lt(issue_a, issue_b);
    gt       = f_lt(issue_b, issue_a);
    eq       = !lt && !gt;                // Covers +0 == -0
    case (issue_op)
      OP_FEQ: begin
        res = eq && !any_nan;
        nv  = any_snan;                   // Quiet NaN is fine for feq
      end
      OP_FLT: begin
        res = lt && !any_nan;
        nv  = any_nan;                    // Signaling compare
      end
      OP_FLE: begin
        res = (lt || eq) && !any_nan;
        nv  = any_nan;
      end
      default: begin
        res = 1'b0;
        nv  = 1'b0;
      end
    endcase
  end

  always_ff @(posedge clk) begin
    if (!rst_n)
      wb_valid <= 1'b0;
    else
      wb_valid <= issue;                  // One cycle latency
  end

  always_ff @(posedge clk) begin
    if (issue) begin
      wb_id     <= issue_id;
      wb_result <= {{(FLEN-1){1'b0}}, res};
      wb_fflags <= f_mk_fflags(nv);
    end
  end

endmodule

// File: hdl/fp_minmax_unit.sv
/* Two-stage fmin/fmax pipeline, classify and compare then select with NaN rules */

module fp_minmax_unit import fp_config_pkg::*, fp_types_pkg::*; (
  input  logic                clk,
  input  logic                rst_n,
  input  logic                issue,
  input  logic [ID_W-1:0]     issue_id,
  input  fp_op_t              issue_op,
  input  logic [FLEN-1:0]     issue_a,
  input  logic [FLEN-1:0]     issue_b,
  output logic                wb_valid,
  output logic [ID_W-1:0]     wb_id,
  output logic [FLEN-1:0]     wb_result,
  output logic [FFLAGS_W-1:0] wb_fflags
);

  logic            s1_valid;
  logic [ID_W-1:0] s1_id;
  fp_op_t          s1_op;
  logic [FLEN-1:0] s1_a, s1_b;
  logic            s1_a_nan, s1_b_nan, s1_a_lt, s1_nv;
  logic            a_lt;
  logic [FLEN-1:0] sel;

  // -0 ranks below +0 here, unlike the compare unit
  assign a_lt = f_lt(issue_a, issue_b) ||
                ((issue_a[FLEN-2:0] == '0) && (issue_b[FLEN-2:0] == '0) &&
                 issue_a[FLEN-1] && !issue_b[FLEN-1]);

  // ####################################################################
  // Stage 1, classify and compare
  // ####################################################################
  always_ff @(posedge clk) begin
    if (issue) begin
      s1_id    <= issue_id;
      s1_op    <= issue_op;
      s1_a     <= issue_a;
      s1_b     <= issue_b;
      s1_a_nan <= f_is_nan(issue_a);
      s1_b_nan <= f_is_nan(issue_b);
      s1_a_lt  <= a_lt;
      s1_nv    <= f_is_snan(issue_a) || f_is_snan(issue_b);
    end
  end

  // ####################################################################
  // Stage 2, select and write back
  // ####################################################################
  always_comb begin
    if (s1_a_nan && s1_b_nan)
      sel = CANON_NAN;
    else if (s1_a_nan)
      sel = s1_b;                         // Other operand wins
    else if (s1_b_nan)
      sel = s1_a;
    else if (s1_op == OP_FMIN)
      sel = s1_a_lt ? s1_a : s1_b;
    else
      sel = s1_a_lt ? s1_b : s1_a;
  end

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      s1_valid <= 1'b0;
      wb_valid <= 1'b0;
    end else begin
      s1_valid <= issue;
      wb_valid <= s1_valid;               // Two cycles after issue
    end
  end

  always_ff @(posedge clk) begin
    if (s1_valid) begin
      wb_id     <= s1_id;
      wb_result <= sel;
      wb_fflags <= f_mk_fflags(s1_nv);
    end
  end

  // Decode must only steer min/max ops here
  a_mm_op: assert property (@(posedge clk) disable iff (!rst_n)
    s1_valid |-> (s1_op inside {OP_FMIN, OP_FMAX}));

endmodule

// File: hdl/fflag_mux.sv
/* Per-unit exception flag tables indexed by tag, read out for the retiring head */

module fflag_mux import fp_config_pkg::*; (
  input  logic                clk,
  input  logic                cmp_wb_valid,
  input  logic [ID_W-1:0]     cmp_wb_id,
  input  logic [FFLAGS_W-1:0] cmp_wb_fflags,
  input  logic                mm_wb_valid,
  input  logic [ID_W-1:0]     mm_wb_id,
  input  logic [FFLAGS_W-1:0] mm_wb_fflags,
  input  logic                head_pop,
  input  logic [ID_W-1:0]     head_id,
  input  logic                head_wb_float,
  output logic [FFLAGS_W-1:0] fflags
);

  logic [FFLAGS_W-1:0] cmp_fflags_table [MAX_IDS];   // Integer writeback unit
  logic [FFLAGS_W-1:0] mm_fflags_table  [MAX_IDS];   // Float writeback unit

  always_ff @(posedge clk) begin
    if (cmp_wb_valid)
      cmp_fflags_table[cmp_wb_id] <= cmp_wb_fflags;
    if (mm_wb_valid)
      mm_fflags_table[mm_wb_id] <= mm_wb_fflags;
  end

  always_comb begin
    if (head_pop)
      fflags = head_wb_float ? mm_fflags_table[head_id] : cmp_fflags_table[head_id];
    else
      fflags = '0;                        // Nothing to accrue
  end

endmodule

// File: hdl/fp_retire.sv
/* In-order retirement, issue-order queue, done bits and result table with
   valid/ready output and sticky accrued flags */

module fp_retire import fp_config_pkg::*; (
  input  logic                clk,
  input  logic                rst_n,
  input  logic                ord_push,
  input  logic [ID_W-1:0]     ord_id,
  input  logic                ord_wb_float,
  input  logic                cmp_wb_valid,
  input  logic [ID_W-1:0]     cmp_wb_id,
  input  logic [FLEN-1:0]     cmp_wb_result,
  input  logic                mm_wb_valid,
  input  logic [ID_W-1:0]     mm_wb_id,
  input  logic [FLEN-1:0]     mm_wb_result,
  output logic                out_valid,
  input  logic                out_ready,
  output logic [ID_W-1:0]     out_id,
  output logic [FLEN-1:0]     out_result,
  output logic                retire_pulse,
  output logic                head_pop,
  output logic [ID_W-1:0]     head_id,
  output logic                head_wb_float,
  input  logic [FFLAGS_W-1:0] fflags,
  output logic [FFLAGS_W-1:0] fflags_accrued
);

  logic [ID_W-1:0]    ord_id_q    [MAX_IDS];   // Issue-order tags
  logic               ord_float_q [MAX_IDS];   // Writeback kind per entry
  logic [FLEN-1:0]    res_table   [MAX_IDS];   // Results by tag
  logic [MAX_IDS-1:0] done;
  logic [ID_W-1:0]    rd_ptr, wr_ptr;
  logic [ID_W:0]      count;

  assign head_id       = ord_id_q[rd_ptr];
  assign head_wb_float = ord_float_q[rd_ptr];
  assign out_valid     = (count != '0) && done[head_id];   // Head finished
  assign head_pop      = out_valid && out_ready;
  assign retire_pulse  = head_pop;
  assign out_id        = head_id;
  assign out_result    = res_table[head_id];  // Stable, tag not reused while live

  // ####################################################################
  // Storage, no reset
  // ####################################################################
  always_ff @(posedge clk) begin
    if (ord_push) begin
      ord_id_q[wr_ptr]    <= ord_id;
      ord_float_q[wr_ptr] <= ord_wb_float;
    end
    if (cmp_wb_valid)
      res_table[cmp_wb_id] <= cmp_wb_result;
    if (mm_wb_valid)
      res_table[mm_wb_id] <= mm_wb_result;
  end

  // ####################################################################
  // Queue control, completion and accrued flags
  // ####################################################################
  always_ff @(posedge clk) begin
    if (!rst_n) begin
      rd_ptr         <= '0;
      wr_ptr         <= '0;
      count          <= '0;
      done           <= '0;
      fflags_accrued <= '0;
    end else begin
      if (ord_push)
        wr_ptr <= wr_ptr + 1'b1;
      if (head_pop) begin
        rd_ptr         <= rd_ptr + 1'b1;
        done[head_id]  <= 1'b0;
        fflags_accrued <= fflags_accrued | fflags;   // Sticky
      end
      if (cmp_wb_valid)
        done[cmp_wb_id] <= 1'b1;
      if (mm_wb_valid)
        done[mm_wb_id] <= 1'b1;
      case ({ord_push, head_pop})
        2'b10:   count <= count + 1'b1;
        2'b01:   count <= count - 1'b1;
        default: ;
      endcase
    end
  end

  // A tag completes once per trip through the queue
  a_cmp_once: assert property (@(posedge clk) disable iff (!rst_n)
    cmp_wb_valid |-> !done[cmp_wb_id]);
  a_mm_once: assert property (@(posedge clk) disable iff (!rst_n)
    mm_wb_valid |-> !done[mm_wb_id]);

endmodule

// File: hdl/fp_flag_top.sv
/* Top level of the FP compare and min/max path with exception flag tracking */

module fp_flag_top import fp_config_pkg::*, fp_types_pkg::*; (
  input  logic                clk,
  input  logic                rst_n,
  input  logic                in_valid,
  output logic                in_ready,
  input  fp_op_t              in_op,
  input  logic [FLEN-1:0]     in_a,
  input  logic [FLEN-1:0]     in_b,
  output logic                out_valid,
  input  logic                out_ready,
  output logic [ID_W-1:0]     out_id,
  output logic [FLEN-1:0]     out_result,
  output logic [FFLAGS_W-1:0] fflags_accrued
);

  logic                cmp_issue, mm_issue;       // Dispatch
  logic [ID_W-1:0]     issue_id;
  fp_op_t              issue_op;
  logic [FLEN-1:0]     issue_a, issue_b;
  logic                ord_push, ord_wb_float;    // Order queue push
  logic [ID_W-1:0]     ord_id;
  logic                retire_pulse;
  logic                cmp_wb_valid, mm_wb_valid; // Writebacks
  logic [ID_W-1:0]     cmp_wb_id, mm_wb_id;
  logic [FLEN-1:0]     cmp_wb_result, mm_wb_result;
  logic [FFLAGS_W-1:0] cmp_wb_fflags, mm_wb_fflags;
  logic                head_pop, head_wb_float;   // Head flag lookup
  logic [ID_W-1:0]     head_id;
  logic [FFLAGS_W-1:0] fflags;

  fp_decode u_decode (.*);

  fp_compare_unit u_cmp (
    .clk, .rst_n, .issue(cmp_issue), .issue_id, .issue_op, .issue_a, .issue_b,
    .wb_valid(cmp_wb_valid), .wb_id(cmp_wb_id), .wb_result(cmp_wb_result),
    .wb_fflags(cmp_wb_fflags)
  );

  fp_minmax_unit u_mm (
    .clk, .rst_n, .issue(mm_issue), .issue_id, .issue_op, .issue_a, .issue_b,
    .wb_valid(mm_wb_valid), .wb_id(mm_wb_id), .wb_result(mm_wb_result),
    .wb_fflags(mm_wb_fflags)
  );

  fflag_mux u_fflag_mux (.*);

  fp_retire u_retire (.*);

endmodule

// File: tb/tb_fp_flag_top.sv
/* Testbench for the FP compare and min/max retirement path, vector driven
   with random output back-pressure and an in-order scoreboard */

module tb_fp_flag_top import fp_config_pkg::*, fp_types_pkg::*; ();

  localparam int          DRIVE_DELAY  = 2;              // After rising edge
  localparam int          READY_LIMIT  = 200;            // Cycles per in_ready wait
  localparam int          DRAIN_LIMIT  = 2000;           // Cycles for final drain
  localparam int          FIRST_STALL  = 20;             // Output held off after reset
  localparam logic [31:0] RAND_SEED    = 32'h310e_ad08;

  logic                clk;
  logic                rst_n;
  logic                in_valid;
  logic                in_ready;
  fp_op_t              in_op;
  logic [FLEN-1:0]     in_a;
  logic [FLEN-1:0]     in_b;
  logic                out_valid;
  logic                out_ready;
  logic [ID_W-1:0]     out_id;
  logic [FLEN-1:0]     out_result;
  logic [FFLAGS_W-1:0] fflags_accrued;

  logic [31:0]         vec_op [$];                      // Vectors from the data file
  logic [31:0]         vec_a [$];
  logic [31:0]         vec_b [$];
  logic [31:0]         vec_res [$];
  logic [31:0]         vec_flags [$];

  logic [ID_W-1:0]     exp_id_q [$];                    // Scoreboard, issue order
  logic [FLEN-1:0]     exp_res_q [$];
  logic [FFLAGS_W-1:0] exp_flags_q [$];
  int                  exp_idx_q [$];
  logic [FFLAGS_W-1:0] exp_accrued;

  int                  accepted;
  int                  retired;
  int                  fail_count;
  int                  hold_cycles;
  int                  stall_left;
  bit                  saw_full;                        // in_ready seen low

  fp_flag_top DUT (.*);

  initial begin
    clk = 1'b0;
    forever #10 clk = ~clk;
  end

  // ####################################################################
  // Failure reporting and compare tasks
  // ####################################################################
  task automatic abort_run();
    $display("Verification failed");
    $fatal(1, "Simulation stopped on error");
  endtask

  task automatic check_result(input logic [ID_W-1:0] exp_id, input logic [ID_W-1:0] got_id,
                              input logic [FLEN-1:0] exp_res, input logic [FLEN-1:0] got_res,
                              input int idx);
    if ((got_id !== exp_id) || (got_res !== exp_res)) begin
      fail_count++;
      $display("Fail at %0t: vector %0d gave id %0d result %h, expected id %0d result %h",
               $time, idx, got_id, got_res, exp_id, exp_res);
      abort_run();
    end
  endtask

  task automatic check_flags(input logic [FFLAGS_W-1:0] exp_f, input logic [FFLAGS_W-1:0] got_f);
    if (got_f !== exp_f) begin
      fail_count++;
      $display("Fail at %0t: fflags_accrued is %b, expected %b after %0d retired",
               $time, got_f, exp_f, retired);
      abort_run();
    end
  endtask

  // ####################################################################
  // Vector file and input driver
  // ####################################################################
  task automatic load_vectors();
    int               fd;
    int               n;
    logic [1023:0]    line_buf;
    logic [31:0]      op, a, b, res, flags;
    fd = $fopen("tb/fp_flag_tests.txt", "r");
    if (fd == 0) begin
      $display("Could not open the test vector file tb/fp_flag_tests.txt");
      abort_run();
    end
    while (!$feof(fd)) begin
      line_buf = '0;
      n = $fgets(line_buf, fd);
      if ((n != 0) && ($sscanf(line_buf, "%h %h %h %h %h", op, a, b, res, flags) == 5)) begin
        vec_op.push_back(op);                             // Comment lines fail the scan
        vec_a.push_back(a);
        vec_b.push_back(b);
        vec_res.push_back(res);
        vec_flags.push_back(flags);
      end
    end
    $fclose(fd);
  endtask

  task automatic drive_vectors();
    int waited;
    for (int i = 0; i < vec_op.size(); i++) begin
      in_valid = 1'b1;
      in_op    = fp_op_t'(vec_op[i][2:0]);
      in_a     = vec_a[i];
      in_b     = vec_b[i];
      waited   = 0;
      forever begin
        @(negedge clk);
        if (in_ready)
          break;
        saw_full = 1'b1;                                  // Back-pressure reached input
        waited++;
        if (waited > READY_LIMIT) begin
          $display("Timed out waiting for in_ready on vector %0d", i);
          abort_run();
        end
      end
      exp_id_q.push_back(ID_W'(accepted % MAX_IDS));      // Round-robin tag
      exp_res_q.push_back(vec_res[i]);
      exp_flags_q.push_back(vec_flags[i][FFLAGS_W-1:0]);
      exp_idx_q.push_back(i);
      accepted++;
      @(posedge clk);                                     // Transfer edge
      #DRIVE_DELAY;
    end
    in_valid = 1'b0;
  endtask

  // ####################################################################
  // Output back-pressure and monitor
  // ####################################################################
  initial begin
    forever begin
      @(posedge clk);
      #DRIVE_DELAY;
      if (!rst_n || (hold_cycles > 0)) begin
        out_ready = 1'b0;                                 // Fill the queue first
        if (rst_n)
          hold_cycles--;
      end else if (stall_left > 0) begin
        out_ready = 1'b0;
        stall_left--;
      end else if (($urandom % 16) == 0) begin
        out_ready  = 1'b0;                                // Long stall burst
        stall_left = 10;
      end else begin
        out_ready = (($urandom % 4) != 0);
      end
    end
  end

  initial begin
    forever begin
      @(negedge clk);
      if (rst_n) begin
        check_flags(exp_accrued, fflags_accrued);         // All earlier pops
        if (out_valid && out_ready) begin
          if (exp_id_q.size() == 0) begin
            $display("Output transfer at %0t with no instruction outstanding", $time);
            abort_run();
          end
          check_result(exp_id_q.pop_front(), out_id, exp_res_q.pop_front(), out_result,
                       exp_idx_q.pop_front());
          exp_accrued = exp_accrued | exp_flags_q.pop_front();   // Visible after edge
          retired++;
        end
      end
    end
  end

  // ####################################################################
  // Main sequence
  // ####################################################################
  initial begin
    int drain;
    void'($urandom(RAND_SEED));
    rst_n       = 1'b0;
    in_valid    = 1'b0;
    in_op       = OP_FEQ;
    in_a        = '0;
    in_b        = '0;
    out_ready   = 1'b0;
    exp_accrued = '0;
    accepted    = 0;
    retired     = 0;
    fail_count  = 0;
    hold_cycles = FIRST_STALL;
    stall_left  = 0;
    saw_full    = 1'b0;
    load_vectors();
    repeat (5) @(posedge clk);
    #DRIVE_DELAY;
    rst_n = 1'b1;
    drive_vectors();
    drain = 0;
    while (retired < vec_op.size()) begin
      @(posedge clk);
      drain++;
      if (drain > DRAIN_LIMIT) begin
        $display("Timed out waiting for all results, %0d of %0d retired",
                 retired, vec_op.size());
        abort_run();
      end
    end
    @(negedge clk);                                       // Last accrued check
    #1;
    if (!saw_full) begin
      fail_count++;
      $display("Fail at %0t: in_ready never dropped under output back-pressure", $time);
    end
    if (fail_count == 0) begin
      $display("Verification passed");
      $finish;
    end else begin
      abort_run();
    end
  end

endmodule

// File: tb/fp_flag_tests.txt
# Columns in hex: opcode a b expected_result expected_flags
# Opcodes 0 feq, 1 flt, 2 fle, 3 fmin, 4 fmax; flags bit 4 is NV
0 3f800000 3f800000 00000001 00
0 3f800000 40000000 00000000 00
0 00000000 80000000 00000001 00
1 bf800000 3f800000 00000001 00
1 40000000 3f800000 00000000 00
1 80000000 00000000 00000000 00
2 00000000 80000000 00000001 00
2 c0000000 bf800000 00000001 00
2 3f800000 bf800000 00000000 00
1 ff800000 c0000000 00000001 00
3 3f800000 40000000 3f800000 00
0 40000000 40000000 00000001 00
4 3f800000 40000000 40000000 00
3 00000000 80000000 80000000 00
4 80000000 00000000 00000000 00
3 c0000000 bf800000 c0000000 00
4 c0000000 bf800000 bf800000 00
3 7fc00000 3f800000 3f800000 00
4 40000000 7fc00000 40000000 00
0 7fc00000 3f800000 00000000 00
0 3f800000 ffc00000 00000000 00
1 7fc00000 3f800000 00000000 10
2 3f800000 7fc00000 00000000 10
0 7f800001 3f800000 00000000 10
1 3f800000 7fa00000 00000000 10
2 7f800001 7f800001 00000000 10
3 7f800001 3f800000 3f800000 10
4 7fc00000 ffc00000 7fc00000 00
3 7f800001 7fc00000 7fc00000 10
4 3f800000 bf800000 3f800000 00
0 00000000 00000000 00000001 00

// File: fp_flag.f
hdl/fp_config_pkg.sv
hdl/fp_types_pkg.sv
hdl/fp_decode.sv
hdl/fp_compare_unit.sv
hdl/fp_minmax_unit.sv
hdl/fflag_mux.sv
hdl/fp_retire.sv
hdl/fp_flag_top.sv
tb/tb_fp_flag_top.sv
